// File: verilog/md_defs.svh
// Width and count macros for the multiply/divide unit
// Operand width, multiplier kernel half width, divider counter width

`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Operand and result width
`define MD_XLEN 32
// Half width handled by the 16x16 kernel
`define MD_HALF 16
// Bit counter of the long divider
`define MD_CNT_W 5

`endif

// File: verilog/md_pkg.sv
// Shared types of the multiply/divide unit
// Operator encoding and the state enumerations of both arithmetic units

package md_pkg;

  // RV32M operator, sign handling comes from signed_mode
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Partial product steps of the multiplier
  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } md_mult_state_e;

  typedef enum logic [2:0] {
    IDLE, ABS_A, ABS_B, COMP, LAST, CHANGE_SIGN, FINISH
  } md_div_state_e;

endpackage

// File: verilog/md_req_if.sv
// Request bundle from the dispatcher to the multiplier and the divider
// Carries enables, operator, operands, operand signs and zero detect

`timescale 1ns/1ns
`include "md_defs.svh"

interface md_req_if import md_pkg::*; ();

  logic                mult_en;
  logic                div_en;
  md_op_e              op;
  logic [`MD_XLEN-1:0] op_a;
  logic [`MD_XLEN-1:0] op_b;
  logic                sign_a;
  logic                sign_b;
  logic                b_zero;

  modport dispatch (output mult_en, div_en, op, op_a, op_b, sign_a, sign_b, b_zero);

  modport mult (input mult_en, op, op_a, op_b, sign_a, sign_b);

  modport div (input div_en, op, op_a, op_b, sign_a, sign_b, b_zero);

endinterface

// File: verilog/md_dispatch.sv
// Operator decode and operand preparation for both arithmetic units
// Result and valid selection from the enabled unit

`timescale 1ns/1ns
`include "md_defs.svh"

module md_dispatch import md_pkg::*; (
  input  logic                en_i,
  input  md_op_e              operator_i,
  input  logic [1:0]          signed_mode_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  input  logic                mult_valid_i,
  input  logic [`MD_XLEN-1:0] mult_result_i,
  input  logic                div_valid_i,
  input  logic [`MD_XLEN-1:0] div_result_i,
  md_req_if.dispatch          req,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o
);

  logic is_mult;
  logic mult_en;
  logic div_en;

  assign is_mult = (operator_i == MD_OP_MULL) || (operator_i == MD_OP_MULH);
  assign mult_en = en_i & is_mult;
  assign div_en  = en_i & ~is_mult;

  assign req.mult_en = mult_en;
  assign req.div_en  = div_en;
  assign req.op      = operator_i;
  assign req.op_a    = op_a_i;
  assign req.op_b    = op_b_i;

  // Operand signs are only meaningful in signed mode
  assign req.sign_a = signed_mode_i[0] & op_a_i[`MD_XLEN-1];
  assign req.sign_b = signed_mode_i[1] & op_b_i[`MD_XLEN-1];
  assign req.b_zero = (op_b_i == '0);

  // Only the enabled unit drives the outputs
  assign result_o = div_en ? div_result_i : mult_result_i;
  assign valid_o  = (mult_en & mult_valid_i) | (div_en & div_valid_i);

endmodule

// File: verilog/md_mult_fast.sv
// Sequential multiplier built on one signed 17x17 multiply-add
// Four partial product steps, MULL done after three and MULH after four

`timescale 1ns/1ns
`include "md_defs.svh"

module md_mult_fast import md_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  md_req_if.mult              req,
  input  logic                ready_i,
  output logic                valid_o,
  output logic [`MD_XLEN-1:0] result_o
);

  // Two guard bits keep the carry of the middle partial products
  localparam int unsigned acc_w = `MD_XLEN + 2;

  md_mult_state_e state_q, state_d;

  logic [acc_w-1:0]        acc_q, acc_d;
  logic signed [acc_w-1:0] accum;
  logic signed [acc_w-1:0] mac_res;
  logic [`MD_HALF-1:0]     mult_op_a;
  logic [`MD_HALF-1:0]     mult_op_b;
  logic                    mult_sign_a;
  logic                    mult_sign_b;
  logic                    is_mull;
  logic                    mult_hold;
  logic                    mult_en_int;

  assign is_mull = (req.op == MD_OP_MULL);

  assign mac_res = $signed({mult_sign_a, mult_op_a}) * $signed({mult_sign_b, mult_op_b})
                   + accum;

  always_comb begin
    mult_op_a   = req.op_a[`MD_HALF-1:0];
    mult_op_b   = req.op_b[`MD_HALF-1:0];
    mult_sign_a = 1'b0;
    mult_sign_b = 1'b0;
    accum       = acc_q;
    acc_d       = mac_res;
    state_d     = state_q;
    valid_o     = 1'b0;
    mult_hold   = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, always unsigned
        accum   = '0;
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh plus the upper half of al*bl
        mult_op_b   = req.op_b[`MD_XLEN-1:`MD_HALF];
        mult_sign_b = req.sign_b;
        accum       = {{(acc_w-`MD_HALF){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
        if (is_mull) begin
          acc_d = {2'b00, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        mult_op_a   = req.op_a[`MD_XLEN-1:`MD_HALF];
        mult_sign_a = req.sign_a;
        if (is_mull) begin
          // Low word is complete here
          accum     = {{(acc_w-`MD_HALF){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
          acc_d     = {2'b00, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
          valid_o   = 1'b1;
          mult_hold = ~ready_i;
          state_d   = ALBL;
        end else begin
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh plus the sign extended upper accumulator
        mult_op_a   = req.op_a[`MD_XLEN-1:`MD_HALF];
        mult_op_b   = req.op_b[`MD_XLEN-1:`MD_HALF];
        mult_sign_a = req.sign_a;
        mult_sign_b = req.sign_b;
        accum       = {{`MD_HALF{acc_q[acc_w-1]}}, acc_q[acc_w-1:`MD_HALF]};
        valid_o     = 1'b1;
        mult_hold   = ~ready_i;
        state_d     = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  assign result_o = acc_d[`MD_XLEN-1:0];

  // Nothing advances while a result waits for ready_i
  assign mult_en_int = req.mult_en & ~mult_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (mult_en_int) begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mult_en_int) begin
      acc_q <= acc_d;
    end
  end

endmodule

// File: verilog/md_div_long.sv
// Restoring long divider, one quotient bit per cycle
// Own 33-bit adder for operand negation and trial subtraction
// Early exit on division by zero

`timescale 1ns/1ns
`include "md_defs.svh"

module md_div_long import md_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  md_req_if.div               req,
  input  logic                ready_i,
  output logic                valid_o,
  output logic [`MD_XLEN-1:0] result_o
);

  md_div_state_e state_q, state_d;

  logic [`MD_CNT_W-1:0] cnt_q, cnt_d;
  logic                 dbz_q, dbz_d;
  logic [`MD_XLEN-1:0]  rem_q, rem_d;
  logic [`MD_XLEN-1:0]  num_q, num_d;
  logic [`MD_XLEN-1:0]  den_q, den_d;
  logic [`MD_XLEN-1:0]  quo_q, quo_d;

  logic [`MD_XLEN-1:0]  add_a;
  logic [`MD_XLEN-1:0]  add_b;
  logic [`MD_XLEN:0]    add_res;
  logic                 is_greater_equal;
  logic [`MD_XLEN-1:0]  next_rem;
  logic [`MD_XLEN-1:0]  next_quo;
  logic [`MD_XLEN-1:0]  one_shift;
  logic                 div_change_sign;
  logic                 rem_change_sign;
  logic                 div_hold;
  logic                 div_en_int;

  // add_a - add_b, top bit is the carry out (no borrow)
  assign add_res = {1'b0, add_a} + {1'b0, ~add_b} + {{`MD_XLEN{1'b0}}, 1'b1};

  assign is_greater_equal = add_res[`MD_XLEN];
  assign next_rem  = is_greater_equal ? add_res[`MD_XLEN-1:0] : rem_q;
  assign one_shift = {{(`MD_XLEN-1){1'b0}}, 1'b1} << cnt_q;
  assign next_quo  = is_greater_equal ? (quo_q | one_shift) : quo_q;

  assign div_change_sign = (req.sign_a ^ req.sign_b) & ~dbz_q;
  assign rem_change_sign = req.sign_a;

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q - 1'b1;
    dbz_d    = dbz_q;
    rem_d    = rem_q;
    num_d    = num_q;
    den_d    = den_q;
    quo_d    = quo_q;
    add_a    = '0;
    add_b    = req.op_b;
    valid_o  = 1'b0;
    div_hold = 1'b0;

    unique case (state_q)
      IDLE: begin
        // Preload the RISC-V result for a zero divisor
        rem_d   = (req.op == MD_OP_DIV) ? '1 : req.op_a;
        dbz_d   = req.b_zero;
        cnt_d   = '1;
        state_d = req.b_zero ? FINISH : ABS_A;
      end

      ABS_A: begin
        add_b   = req.op_a;
        quo_d   = '0;
        num_d   = req.sign_a ? add_res[`MD_XLEN-1:0] : req.op_a;
        cnt_d   = '1;
        state_d = ABS_B;
      end

      ABS_B: begin
        add_b   = req.op_b;
        den_d   = req.sign_b ? add_res[`MD_XLEN-1:0] : req.op_b;
        rem_d   = {{(`MD_XLEN-1){1'b0}}, num_q[`MD_XLEN-1]};
        cnt_d   = '1;
        state_d = COMP;
      end

      COMP: begin
        // Trial subtract, then shift in the next numerator bit
        add_a   = rem_q;
        add_b   = den_q;
        rem_d   = {next_rem[`MD_XLEN-2:0], num_q[cnt_d]};
        quo_d   = next_quo;
        state_d = (cnt_q == 1) ? LAST : COMP;
      end

      LAST: begin
        add_a   = rem_q;
        add_b   = den_q;
        rem_d   = (req.op == MD_OP_DIV) ? next_quo : next_rem;
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        add_b = rem_q;
        if (req.op == MD_OP_DIV) begin
          rem_d = div_change_sign ? add_res[`MD_XLEN-1:0] : rem_q;
        end else begin
          rem_d = rem_change_sign ? add_res[`MD_XLEN-1:0] : rem_q;
        end
        state_d = FINISH;
      end

      FINISH: begin
        valid_o  = 1'b1;
        div_hold = ~ready_i;
        state_d  = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign result_o = rem_q;

  assign div_en_int = req.div_en & ~div_hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      dbz_q   <= 1'b0;
    end else if (div_en_int) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      dbz_q   <= dbz_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_en_int) begin
      rem_q <= rem_d;
      num_q <= num_d;
      den_q <= den_d;
      quo_q <= quo_d;
    end
  end

endmodule

// File: verilog/multdiv_top.sv
// RV32M multiply/divide unit top level
// Dispatcher, 16x16 sequential multiplier and long divider

`timescale 1ns/1ns
`include "md_defs.svh"

module multdiv_top import md_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_op_e              operator_i,
  input  logic [1:0]          signed_mode_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  input  logic                ready_i,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o
);

  logic                mult_valid;
  logic [`MD_XLEN-1:0] mult_result;
  logic                div_valid;
  logic [`MD_XLEN-1:0] div_result;

  md_req_if req_if ();

  md_dispatch md_dispatch_i (
    .en_i          (en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .mult_valid_i  (mult_valid),
    .mult_result_i (mult_result),
    .div_valid_i   (div_valid),
    .div_result_i  (div_result),
    .req           (req_if.dispatch),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  md_mult_fast md_mult_fast_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req      (req_if.mult),
    .ready_i  (ready_i),
    .valid_o  (mult_valid),
    .result_o (mult_result)
  );

  md_div_long md_div_long_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req      (req_if.div),
    .ready_i  (ready_i),
    .valid_o  (div_valid),
    .result_o (div_result)
  );

endmodule

// File: verif/multdiv_sva.sv
// Concurrent assertions on the multiply/divide top-level ports
// Known valid, result hold under back-pressure, MULL latency from idle

`timescale 1ns/1ns
`include "md_defs.svh"

module multdiv_sva import md_pkg::*; (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                en_i,
  input md_op_e              operator_i,
  input logic                ready_i,
  input logic [`MD_XLEN-1:0] result_o,
  input logic                valid_o
);

  int unsigned fail_count = 0;

  valid_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(valid_o))
    else begin
      $error("valid_o is unknown after reset");
      fail_count++;
    end

  // A stalled result keeps its value until accepted
  result_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o))
    else begin
      $error("result_o changed or valid_o dropped while ready_i was low");
      fail_count++;
    end

  // MULL from idle gives valid in the third cycle
  mull_latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(en_i) && (operator_i == MD_OP_MULL) |-> !valid_o ##1 !valid_o ##1 valid_o)
    else begin
      $error("MULL valid_o did not arrive two cycles after en_i rose");
      fail_count++;
    end

endmodule

bind multdiv_top multdiv_sva multdiv_sva_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .en_i       (en_i),
  .operator_i (operator_i),
  .ready_i    (ready_i),
  .result_o   (result_o),
  .valid_o    (valid_o)
);

// File: verif/tb_multdiv.sv
// Testbench for the RV32M multiply/divide unit
// Directed and LCG table entries, RV32M reference model, checks, watchdog

`timescale 1ns/1ns
`include "md_defs.svh"

module tb_multdiv import md_pkg::*; ();

  localparam int clk_period = 40;
  localparam int n_directed = 23;
  localparam int n_random   = 16;
  localparam int n_tests    = n_directed + n_random;
  localparam int max_wait   = 45;

  logic                clk_i;
  logic                rst_ni;
  logic                en_i;
  md_op_e              operator_i;
  logic [1:0]          signed_mode_i;
  logic [`MD_XLEN-1:0] op_a_i;
  logic [`MD_XLEN-1:0] op_b_i;
  logic                ready_i;
  logic [`MD_XLEN-1:0] result_o;
  logic                valid_o;

  md_op_e              tbl_op    [n_tests];
  logic [1:0]          tbl_mode  [n_tests];
  logic [`MD_XLEN-1:0] tbl_a     [n_tests];
  logic [`MD_XLEN-1:0] tbl_b     [n_tests];
  int                  tbl_delay [n_tests];
  logic [`MD_XLEN-1:0] tbl_exp   [n_tests];

  int          n_fill;
  int          error_count;
  int          assert_fails;
  int          errors_before;
  int          idx;
  int          h;
  int          wait_cycles;
  logic        seen;
  logic [31:0] lcg_state;

  multdiv_top multdiv_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // RV32M rules with signed_mode selecting the sign of each operand
  function automatic logic [`MD_XLEN-1:0] ref_result(input md_op_e op, input logic [1:0] mode,
                                                    input logic [`MD_XLEN-1:0] a,
                                                    input logic [`MD_XLEN-1:0] b);
    logic                  neg_a;
    logic                  neg_b;
    logic [2*`MD_XLEN-1:0] prod;
    logic [`MD_XLEN-1:0]   mag_a;
    logic [`MD_XLEN-1:0]   mag_b;
    logic [`MD_XLEN-1:0]   quo;
    logic [`MD_XLEN-1:0]   rem;
    neg_a = mode[0] & a[`MD_XLEN-1];
    neg_b = mode[1] & b[`MD_XLEN-1];
    prod  = {{`MD_XLEN{neg_a}}, a} * {{`MD_XLEN{neg_b}}, b};
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    if (b == '0) begin
      quo = '1;
      rem = a;
    end else begin
      quo = mag_a / mag_b;
      rem = mag_a % mag_b;
      if (neg_a ^ neg_b) quo = -quo;
      if (neg_a) rem = -rem;
    end
    case (op)
      MD_OP_MULL: return prod[`MD_XLEN-1:0];
      MD_OP_MULH: return prod[2*`MD_XLEN-1:`MD_XLEN];
      MD_OP_DIV:  return quo;
      default:    return rem;
    endcase
  endfunction

  task automatic add_entry(input md_op_e op, input logic [1:0] mode,
                           input logic [`MD_XLEN-1:0] a, input logic [`MD_XLEN-1:0] b,
                           input int delay, input logic [`MD_XLEN-1:0] expected);
    tbl_op[n_fill]    = op;
    tbl_mode[n_fill]  = mode;
    tbl_a[n_fill]     = a;
    tbl_b[n_fill]     = b;
    tbl_delay[n_fill] = delay;
    tbl_exp[n_fill]   = expected;
    n_fill++;
  endtask

  // Multiply and divide alternate at first
  // A nonzero delay leaves one idle cycle after the entry
  task automatic fill_directed_entries();
    add_entry(MD_OP_MULL, 2'b00, 32'h00001234, 32'h00005678, 0, 32'h06260060);
    add_entry(MD_OP_DIV,  2'b11, 32'hFFFFFFF9, 32'h00000002, 0, 32'hFFFFFFFD);
    add_entry(MD_OP_MULH, 2'b00, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'hFFFFFFFE);
    add_entry(MD_OP_REM,  2'b11, 32'hFFFFFFF9, 32'h00000002, 0, 32'hFFFFFFFF);
    add_entry(MD_OP_MULL, 2'b11, 32'hFFFFFFFE, 32'h00000007, 3, 32'hFFFFFFF2);
    add_entry(MD_OP_DIV,  2'b00, 32'hFFFFFFF9, 32'h00000002, 5, 32'h7FFFFFFC);
    add_entry(MD_OP_MULL, 2'b00, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'h00000001);
    add_entry(MD_OP_REM,  2'b00, 32'hFFFFFFF9, 32'h00000002, 0, 32'h00000001);
    add_entry(MD_OP_MULH, 2'b11, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'h00000000);
    add_entry(MD_OP_DIV,  2'b11, 32'h00000007, 32'hFFFFFFFE, 0, 32'hFFFFFFFD);
    add_entry(MD_OP_MULH, 2'b11, 32'h80000000, 32'h80000000, 2, 32'h40000000);
    add_entry(MD_OP_REM,  2'b11, 32'h00000007, 32'hFFFFFFFE, 0, 32'h00000001);
    add_entry(MD_OP_MULH, 2'b01, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'hFFFFFFFF);
    add_entry(MD_OP_DIV,  2'b11, 32'h80000000, 32'hFFFFFFFF, 0, 32'h80000000);
    add_entry(MD_OP_MULH, 2'b01, 32'h00000002, 32'h80000000, 0, 32'h00000001);
    add_entry(MD_OP_REM,  2'b11, 32'h80000000, 32'hFFFFFFFF, 0, 32'h00000000);
    add_entry(MD_OP_DIV,  2'b00, 32'h12345678, 32'h00000000, 4, 32'hFFFFFFFF);
    add_entry(MD_OP_MULL, 2'b11, 32'h80000000, 32'hFFFFFFFF, 0, 32'h80000000);
    add_entry(MD_OP_REM,  2'b00, 32'h12345678, 32'h00000000, 0, 32'h12345678);
    add_entry(MD_OP_DIV,  2'b11, 32'h80000001, 32'h00000000, 0, 32'hFFFFFFFF);
    add_entry(MD_OP_REM,  2'b11, 32'h80000001, 32'h00000000, 0, 32'h80000001);
    add_entry(MD_OP_DIV,  2'b00, 32'h00000064, 32'h00000007, 0, 32'h0000000E);
    add_entry(MD_OP_REM,  2'b00, 32'h00000064, 32'h00000007, 0, 32'h00000002);
  endtask

  task automatic fill_random_entries();
    md_op_e              op;
    logic [1:0]          mode;
    logic [`MD_XLEN-1:0] a;
    logic [`MD_XLEN-1:0] b;
    int                  delay;
    for (int i = 0; i < n_random; i++) begin
      lcg_state = lcg_next(lcg_state);
      op   = md_op_e'(lcg_state[17:16]);
      mode = lcg_state[21:20];
      // Divides use RV32M DIV/DIVU style modes only
      if (op == MD_OP_DIV || op == MD_OP_REM) mode = {2{mode[0]}};
      delay = (lcg_state[25:24] == 2'b00) ? int'(lcg_state[27:26]) + 1 : 0;
      lcg_state = lcg_next(lcg_state);
      a = lcg_state;
      lcg_state = lcg_next(lcg_state);
      b = lcg_state >> lcg_state[28:24];
      add_entry(op, mode, a, b, delay, ref_result(op, mode, a, b));
    end
  endtask

  task automatic check_result(input int test, input logic [`MD_XLEN-1:0] got,
                              input logic [`MD_XLEN-1:0] expected);
    if (got !== expected) begin
      $display("FAIL test %0d result_o got %h expected %h", test, got, expected);
      error_count++;
    end
  endtask

  task automatic check_valid(input int test, input md_op_e op, input logic present);
    if (present !== 1'b1) begin
      $display("test %0d: valid_o missing for the %s operation", test, op.name());
      error_count++;
    end
  endtask

  initial begin
    #(n_tests * max_wait * clk_period);
    $display("Watchdog expired before all tests completed");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_ni        = 1'b0;
    en_i          = 1'b0;
    operator_i    = MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    ready_i       = 1'b0;
    error_count   = 0;
    assert_fails  = 0;
    n_fill        = 0;
    lcg_state     = 32'd9;
    fill_directed_entries();
    fill_random_entries();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (idx = 0; idx < n_tests; idx++) begin
      errors_before = error_count;
      en_i          <= 1'b1;
      operator_i    <= tbl_op[idx];
      signed_mode_i <= tbl_mode[idx];
      op_a_i        <= tbl_a[idx];
      op_b_i        <= tbl_b[idx];
      ready_i       <= (tbl_delay[idx] == 0);
      seen        = 1'b0;
      wait_cycles = 0;
      while (!seen && wait_cycles < max_wait) begin
        @(negedge clk_i);
        seen = valid_o;
        wait_cycles++;
      end
      check_valid(idx, tbl_op[idx], seen);
      if (seen) begin
        check_result(idx, result_o, tbl_exp[idx]);
        // Result must hold while ready_i stays low
        for (h = 0; h < tbl_delay[idx]; h++) begin
          @(posedge clk_i);
          if (h == tbl_delay[idx] - 1) ready_i <= 1'b1;
          @(negedge clk_i);
          check_valid(idx, tbl_op[idx], valid_o);
          check_result(idx, result_o, tbl_exp[idx]);
        end
      end
      @(posedge clk_i);
      $display("test %0d %s mode %b a %h b %h expected %h: %s", idx, tbl_op[idx].name(),
               tbl_mode[idx], tbl_a[idx], tbl_b[idx], tbl_exp[idx],
               (error_count == errors_before) ? "ok" : "mismatch");
      if (tbl_delay[idx] != 0) begin
        en_i <= 1'b0;
        @(posedge clk_i);
      end
    end
    en_i <= 1'b0;
    @(posedge clk_i);
    assert_fails = multdiv_top_i.multdiv_sva_i.fail_count;
    $display("%0d tests run, %0d checks failed, %0d assertions failed", n_tests, error_count,
             assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: multdiv

export_include_dirs:
  - verilog

sources:
  - verilog/md_pkg.sv
  - verilog/md_req_if.sv
  - verilog/md_dispatch.sv
  - verilog/md_mult_fast.sv
  - verilog/md_div_long.sv
  - verilog/multdiv_top.sv
  - target: test
    files:
      - verif/multdiv_sva.sv
      - verif/tb_multdiv.sv

// File: build.f
+incdir+verilog
verilog/md_pkg.sv
verilog/md_req_if.sv
verilog/md_dispatch.sv
verilog/md_mult_fast.sv
verilog/md_div_long.sv
verilog/multdiv_top.sv
verif/multdiv_sva.sv
verif/tb_multdiv.sv
